/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module exu_tb -o exu_sim; then
	echo "Verilator build failed"
	exit 1
fi
output=$(./obj_dir/exu_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if printf '%s\n' "$output" | grep -qx 'TEST RESULT: PASS'; then
	exit 0
fi
exit 1

/* sim.f */
src/exu_pkg.sv
src/exu_alu.sv
src/exu_multiplier.sv
src/exu_divider.sv
src/step_counter.sv
src/exu_control.sv
src/exu_top.sv
tests/exu_tb.sv

/* src/exu_alu.sv */
module exu_alu #(
	parameter int data_width = exu_pkg::data_width
) (
	input  logic [data_width-1:0] pc,
	input  logic [data_width-1:0] src1,
	input  logic [data_width-1:0] src2,
	input  logic [data_width-1:0] imm,
	input  exu_pkg::src_sel_e     src_sel,
	input  exu_pkg::exu_op_e      op,
	output logic [data_width-1:0] operand_a,
	output logic [data_width-1:0] operand_b,
	output logic [data_width-1:0] alu_result
);

	logic [4:0] shamt;
	logic       signed_less;
	logic       unsigned_less;
	logic       equal;

	always_comb begin
		operand_a = src1;
		operand_b = src2;
		case (src_sel)
			exu_pkg::src_rs1_imm: operand_b = imm;
			exu_pkg::src_pc_4: begin
				operand_a = pc;
				operand_b = data_width'(4);
			end
			exu_pkg::src_pc_imm: begin
				operand_a = pc;
				operand_b = imm;
			end
			default: ; // rs1/rs2 is the default pair.
		endcase
	end

	assign shamt         = operand_b[4:0]; // only the low five bits matter for RV32.
	assign signed_less   = $signed(operand_a) < $signed(operand_b);
	assign unsigned_less = operand_a < operand_b;
	assign equal         = operand_a == operand_b;

	// branch compares return 0 or 1 so the result register carries the taken bit.
	always_comb begin
		case (op)
			exu_pkg::op_add:  alu_result = operand_a + operand_b;
			exu_pkg::op_sub:  alu_result = operand_a - operand_b;
			exu_pkg::op_sll:  alu_result = operand_a << shamt;
			exu_pkg::op_slt:  alu_result = data_width'(signed_less);
			exu_pkg::op_sltu: alu_result = data_width'(unsigned_less);
			exu_pkg::op_xor:  alu_result = operand_a ^ operand_b;
			exu_pkg::op_srl:  alu_result = operand_a >> shamt;
			exu_pkg::op_sra:  alu_result = $signed(operand_a) >>> shamt;
			exu_pkg::op_or:   alu_result = operand_a | operand_b;
			exu_pkg::op_and:  alu_result = operand_a & operand_b;
			exu_pkg::op_beq:  alu_result = data_width'(equal);
			exu_pkg::op_bne:  alu_result = data_width'(!equal);
			exu_pkg::op_blt:  alu_result = data_width'(signed_less);
			exu_pkg::op_bge:  alu_result = data_width'(!signed_less);
			exu_pkg::op_bltu: alu_result = data_width'(unsigned_less);
			exu_pkg::op_bgeu: alu_result = data_width'(!unsigned_less);
			default:          alu_result = '0; // multiply and divide come from their own units.
		endcase
	end

endmodule

/* src/exu_control.sv */
module exu_control #(
	parameter int data_width = exu_pkg::data_width
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  id_to_ex,
	input  logic                  ex_to_wb,
	input  exu_pkg::exu_op_e      op,
	input  logic [data_width-1:0] alu_result,
	input  logic [data_width-1:0] product_result,
	input  logic [data_width-1:0] divide_result,
	input  logic                  last_step,
	output logic                  start_mul,
	output logic                  start_div,
	output logic                  count_load,
	output logic                  exu_stall,
	output logic                  exu_result_valid,
	output logic [data_width-1:0] exu_result
);

	exu_pkg::exu_state_e   state_q;
	exu_pkg::exu_state_e   state_d;
	logic                  accept;
	logic                  mul_op;
	logic                  div_op;
	logic                  use_div_q;
	logic                  last_q;
	logic                  result_load;
	logic [data_width-1:0] alu_hold_q;

	assign accept = (state_q == exu_pkg::st_idle) && id_to_ex; // starts are dropped while busy.
	assign mul_op = op inside {exu_pkg::op_mul, exu_pkg::op_mulh, exu_pkg::op_mulhsu,
		exu_pkg::op_mulhu};
	assign div_op = op inside {exu_pkg::op_div, exu_pkg::op_divu, exu_pkg::op_rem,
		exu_pkg::op_remu};

	assign start_mul  = accept && mul_op;
	assign start_div  = accept && div_op;
	assign count_load = start_mul || start_div;

	always_comb begin
		state_d     = state_q;
		result_load = 1'b0;
		case (state_q)
			exu_pkg::st_idle: begin
				if (id_to_ex)
					state_d = count_load ? exu_pkg::st_iterate : exu_pkg::st_alu;
			end
			exu_pkg::st_alu: begin
				result_load = 1'b1;
				state_d     = exu_pkg::st_done;
			end
			exu_pkg::st_iterate: begin
				// last_q marks the cycle after the final step, when the unit output has settled.
				if (last_q) begin
					result_load = 1'b1;
					state_d     = exu_pkg::st_done;
				end
			end
			default: begin
				if (ex_to_wb)
					state_d = exu_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q    <= exu_pkg::st_idle;
			last_q     <= 1'b0;
			use_div_q  <= 1'b0;
			exu_result <= '0;
		end else begin
			state_q <= state_d;
			last_q  <= last_step;
			if (accept)
				use_div_q <= div_op;
			if (result_load)
				exu_result <= (state_q == exu_pkg::st_alu) ? alu_hold_q :
					(use_div_q ? divide_result : product_result);
		end
	end

	// decode inputs may move after id_to_ex, so the ALU value is caught on that edge.
	always_ff @(posedge clock) begin
		if (accept)
			alu_hold_q <= alu_result;
	end

	assign exu_stall        = (state_q == exu_pkg::st_alu) || (state_q == exu_pkg::st_iterate);
	assign exu_result_valid = state_q == exu_pkg::st_done;

endmodule

/* src/exu_divider.sv */
module exu_divider #(
	parameter int data_width = exu_pkg::data_width
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  logic                  step_enable,
	input  exu_pkg::exu_op_e      op,
	input  logic [data_width-1:0] dividend,
	input  logic [data_width-1:0] divisor,
	output logic [data_width-1:0] divide_result
);

	logic                  signed_op;
	logic                  a_neg;
	logic                  b_neg;
	logic [data_width-1:0] a_mag;
	logic [data_width-1:0] b_mag;
	logic [data_width-1:0] divisor_q;
	logic [data_width-1:0] quot_q;
	logic [data_width-1:0] rem_q;
	logic                  q_neg_q;
	logic                  r_neg_q;
	logic                  rem_sel_q;
	logic                  zero_q;
	logic [data_width:0]   shifted;
	logic [data_width:0]   diff;
	logic [data_width-1:0] quotient;
	logic [data_width-1:0] remainder;

	assign signed_op = op inside {exu_pkg::op_div, exu_pkg::op_rem};
	assign a_neg     = signed_op && dividend[data_width-1];
	assign b_neg     = signed_op && divisor[data_width-1];
	assign a_mag     = a_neg ? -dividend : dividend;
	assign b_mag     = b_neg ? -divisor : divisor;

	// bring the next dividend bit into the partial remainder and try the subtract.
	assign shifted = {rem_q, quot_q[data_width-1]};
	assign diff    = shifted - {1'b0, divisor_q};

	always_ff @(posedge clock) begin
		if (reset) begin
			q_neg_q   <= 1'b0;
			r_neg_q   <= 1'b0;
			rem_sel_q <= 1'b0;
			zero_q    <= 1'b0;
		end else if (start) begin
			q_neg_q   <= a_neg ^ b_neg;
			r_neg_q   <= a_neg; // remainder follows the dividend's sign.
			rem_sel_q <= op inside {exu_pkg::op_rem, exu_pkg::op_remu};
			zero_q    <= divisor == '0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			divisor_q <= b_mag;
			quot_q    <= a_mag; // quotient bits shift in as dividend bits shift out.
			rem_q     <= '0;
		end else if (step_enable) begin
			if (!diff[data_width]) begin
				rem_q  <= diff[data_width-1:0];
				quot_q <= {quot_q[data_width-2:0], 1'b1};
			end else begin
				rem_q  <= shifted[data_width-1:0];
				quot_q <= {quot_q[data_width-2:0], 1'b0};
			end
		end
	end

	// a zero divisor leaves the dividend magnitude in rem_q, so the sign fix gives the dividend back.
	// the most negative number over -1 wraps to itself with a zero remainder on this path.
	assign quotient  = zero_q ? '1 : (q_neg_q ? -quot_q : quot_q);
	assign remainder = r_neg_q ? -rem_q : rem_q;

	assign divide_result = rem_sel_q ? remainder : quotient;

endmodule

/* src/exu_multiplier.sv */
module exu_multiplier #(
	parameter int data_width = exu_pkg::data_width
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  logic                  step_enable,
	input  exu_pkg::exu_op_e      op,
	input  logic [data_width-1:0] multiplicand,
	input  logic [data_width-1:0] multiplier,
	output logic [data_width-1:0] product_result
);

	logic                    a_neg;
	logic                    b_neg;
	logic [data_width-1:0]   a_mag;
	logic [data_width-1:0]   b_mag;
	logic [data_width-1:0]   mcand_q;
	logic [2*data_width-1:0] prod_q;
	logic                    neg_q;
	logic                    high_q;
	logic [data_width:0]     partial;
	logic [2*data_width-1:0] signed_prod;

	// mul, mulh and mulhsu treat the multiplicand as signed. Only mul and mulh sign the multiplier.
	assign a_neg = multiplicand[data_width-1] &&
		(op inside {exu_pkg::op_mul, exu_pkg::op_mulh, exu_pkg::op_mulhsu});
	assign b_neg = multiplier[data_width-1] &&
		(op inside {exu_pkg::op_mul, exu_pkg::op_mulh});
	assign a_mag = a_neg ? -multiplicand : multiplicand;
	assign b_mag = b_neg ? -multiplier : multiplier;

	// the upper half accumulates while the multiplier bits drain out of the lower half.
	assign partial = {1'b0, prod_q[2*data_width-1:data_width]} +
		(prod_q[0] ? {1'b0, mcand_q} : '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			neg_q  <= 1'b0;
			high_q <= 1'b0;
		end else if (start) begin
			neg_q  <= a_neg ^ b_neg;
			high_q <= op != exu_pkg::op_mul;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			mcand_q <= a_mag;
			prod_q  <= {{data_width{1'b0}}, b_mag};
		end else if (step_enable) begin
			prod_q <= {partial, prod_q[data_width-1:1]};
		end
	end

	assign signed_prod    = neg_q ? -prod_q : prod_q;
	assign product_result = high_q ? signed_prod[2*data_width-1:data_width] :
		signed_prod[data_width-1:0];

endmodule

/* src/exu_pkg.sv */
package exu_pkg;

	parameter int data_width = 32; // operand and result width.

	// operations handled by the execute stage. Decode maps funct3/funct7 onto these.
	typedef enum logic [4:0] {
		op_add,
		op_sub,
		op_sll,
		op_slt,
		op_sltu,
		op_xor,
		op_srl,
		op_sra,
		op_or,
		op_and,
		op_beq,
		op_bne,
		op_blt,
		op_bge,
		op_bltu,
		op_bgeu,
		op_mul,
		op_mulh,
		op_mulhsu,
		op_mulhu,
		op_div,
		op_divu,
		op_rem,
		op_remu
	} exu_op_e;

	typedef enum logic [1:0] {
		src_rs1_rs2, // register-register ops and branch compares.
		src_rs1_imm,
		src_pc_4,    // link address for jal/jalr.
		src_pc_imm
	} src_sel_e;

	typedef enum logic [1:0] {
		st_idle,
		st_alu,
		st_iterate,
		st_done
	} exu_state_e;

endpackage

/* src/exu_top.sv */
module exu_top #(
	parameter int data_width = exu_pkg::data_width
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [data_width-1:0] pc,
	input  logic [data_width-1:0] src1,
	input  logic [data_width-1:0] src2,
	input  logic [data_width-1:0] imm,
	input  exu_pkg::src_sel_e     src_sel,
	input  exu_pkg::exu_op_e      op,
	input  logic                  id_to_ex,
	input  logic                  ex_to_wb,
	output logic                  zero_flag,
	output logic                  exu_stall,
	output logic                  exu_result_valid,
	output logic [data_width-1:0] exu_result
);

	logic [data_width-1:0] operand_a;
	logic [data_width-1:0] operand_b;
	logic [data_width-1:0] alu_result;
	logic [data_width-1:0] product_result;
	logic [data_width-1:0] divide_result;
	logic                  start_mul;
	logic                  start_div;
	logic                  count_load;
	logic                  step_enable;
	logic                  last_step;

	exu_alu #(.data_width(data_width)) i_exu_alu (
		.pc(pc),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.src_sel(src_sel),
		.op(op),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.alu_result(alu_result)
	);

	// one iteration per result bit in both iterative units.
	step_counter #(.steps(data_width)) i_step_counter (
		.clock(clock),
		.reset(reset),
		.count_load(count_load),
		.step_enable(step_enable),
		.last_step(last_step)
	);

	exu_multiplier #(.data_width(data_width)) i_exu_multiplier (
		.clock(clock),
		.reset(reset),
		.start(start_mul),
		.step_enable(step_enable),
		.op(op),
		.multiplicand(operand_a),
		.multiplier(operand_b),
		.product_result(product_result)
	);

	exu_divider #(.data_width(data_width)) i_exu_divider (
		.clock(clock),
		.reset(reset),
		.start(start_div),
		.step_enable(step_enable),
		.op(op),
		.dividend(operand_a),
		.divisor(operand_b),
		.divide_result(divide_result)
	);

	exu_control #(.data_width(data_width)) i_exu_control (
		.clock(clock),
		.reset(reset),
		.id_to_ex(id_to_ex),
		.ex_to_wb(ex_to_wb),
		.op(op),
		.alu_result(alu_result),
		.product_result(product_result),
		.divide_result(divide_result),
		.last_step(last_step),
		.start_mul(start_mul),
		.start_div(start_div),
		.count_load(count_load),
		.exu_stall(exu_stall),
		.exu_result_valid(exu_result_valid),
		.exu_result(exu_result)
	);

	assign zero_flag = ~|exu_result;

endmodule

/* src/step_counter.sv */
module step_counter #(
	parameter int steps = 32
) (
	input  logic clock,
	input  logic reset,
	input  logic count_load,
	output logic step_enable,
	output logic last_step
);

	localparam int count_width = $clog2(steps + 1);

	logic [count_width-1:0] count_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			count_q <= '0;
		end else if (count_load) begin
			count_q <= count_width'(steps);
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	assign step_enable = count_q != '0;
	assign last_step   = count_q == count_width'(1); // the final iteration is on the next edge.

endmodule

/* tests/exu_tb.sv */
module exu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int w             = exu_pkg::data_width;
	localparam int timeout_edges = 40; // the longest op takes 33 edges.
	localparam logic [w-1:0] most_neg = {1'b1, {(w-1){1'b0}}};

	logic                  clock = 1'b0;
	logic                  reset;
	logic [w-1:0]          pc;
	logic [w-1:0]          src1;
	logic [w-1:0]          src2;
	logic [w-1:0]          imm;
	exu_pkg::src_sel_e     src_sel;
	exu_pkg::exu_op_e      op;
	logic                  id_to_ex;
	logic                  ex_to_wb;
	logic                  zero_flag;
	logic                  exu_stall;
	logic                  exu_result_valid;
	logic [w-1:0]          exu_result;

	// multiply and divide corners, which give a zero divisor and the signed overflow pair.
	logic [w-1:0] corner [6] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h7};
	logic [w-1:0] lhs [6]    = '{32'h5, 32'h3, 32'h7, 32'h8000_0000, 32'hffff_ffff, 32'h0};
	logic [w-1:0] rhs [6]    = '{32'h5, 32'h7, 32'h3, 32'h7fff_ffff, 32'h0, 32'hffff_ffff};

	exu_top i_exu_top (.*);

	always #5 clock = ~clock;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input logic [w-1:0] actual, expected);
		if (actual !== expected)
			stop_with_error($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name,
				actual, expected));
	endtask

	task automatic check_flag(input string name, input logic actual, expected);
		if (actual !== expected)
			stop_with_error($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name,
				actual, expected));
	endtask

	task automatic check_op(input exu_pkg::exu_op_e code, input logic [w-1:0] actual, expected);
		if (actual !== expected)
			stop_with_error($sformatf("ERROR exu_result for %s: got 0x%08h, expected 0x%08h",
				code.name(), actual, expected));
	endtask

	// expected result worked out from the RV32IM rules for each operation.
	function automatic logic [w-1:0] expected_result(input exu_pkg::exu_op_e code,
			input exu_pkg::src_sel_e sel, input logic [w-1:0] pc_v, a, b, imm_v);
		logic [w-1:0]   x;
		logic [w-1:0]   y;
		logic [w-1:0]   r;
		int             sx;
		int             sy;
		logic [2*w-1:0] prod;
		x  = (sel == exu_pkg::src_pc_4 || sel == exu_pkg::src_pc_imm) ? pc_v : a;
		y  = (sel == exu_pkg::src_rs1_rs2) ? b : (sel == exu_pkg::src_pc_4) ? w'(4) : imm_v;
		sx = x;
		sy = y;
		case (code) // low half of a product is the same for any signedness.
			exu_pkg::op_mulh:   prod = {{w{x[w-1]}}, x} * {{w{y[w-1]}}, y};
			exu_pkg::op_mulhsu: prod = {{w{x[w-1]}}, x} * {{w{1'b0}}, y};
			default:            prod = {{w{1'b0}}, x} * {{w{1'b0}}, y};
		endcase
		case (code)
			exu_pkg::op_add:  r = x + y;
			exu_pkg::op_sub:  r = x - y;
			exu_pkg::op_sll:  r = x << y[4:0];
			exu_pkg::op_slt:  r = (sx < sy) ? 1 : 0;
			exu_pkg::op_sltu: r = (x < y) ? 1 : 0;
			exu_pkg::op_xor:  r = x ^ y;
			exu_pkg::op_srl:  r = x >> y[4:0];
			exu_pkg::op_sra:  r = sx >>> y[4:0];
			exu_pkg::op_or:   r = x | y;
			exu_pkg::op_and:  r = x & y;
			exu_pkg::op_beq:  r = (x == y) ? 1 : 0;
			exu_pkg::op_bne:  r = (x != y) ? 1 : 0;
			exu_pkg::op_blt:  r = (sx < sy) ? 1 : 0;
			exu_pkg::op_bge:  r = (sx >= sy) ? 1 : 0;
			exu_pkg::op_bltu: r = (x < y) ? 1 : 0;
			exu_pkg::op_bgeu: r = (x >= y) ? 1 : 0;
			exu_pkg::op_mul:  r = prod[w-1:0];
			exu_pkg::op_mulh, exu_pkg::op_mulhsu, exu_pkg::op_mulhu: r = prod[2*w-1:w];
			exu_pkg::op_div, exu_pkg::op_rem: begin
				if (y == '0)
					r = (code == exu_pkg::op_div) ? '1 : x;
				else if (x == most_neg && y == '1)
					r = (code == exu_pkg::op_div) ? x : '0;
				else
					r = (code == exu_pkg::op_div) ? sx / sy : sx % sy;
			end
			default: begin
				if (y == '0)
					r = (code == exu_pkg::op_divu) ? '1 : x;
				else
					r = (code == exu_pkg::op_divu) ? x / y : x % y;
			end
		endcase
		return r;
	endfunction

	task automatic issue_op(input exu_pkg::exu_op_e code, input exu_pkg::src_sel_e sel,
			input logic [w-1:0] pc_v, a, b, imm_v);
		@(posedge clock);
		op       <= code;
		src_sel  <= sel;
		pc       <= pc_v;
		src1     <= a;
		src2     <= b;
		imm      <= imm_v;
		id_to_ex <= 1'b1;
		@(posedge clock);
		id_to_ex <= 1'b0;
		pc       <= $urandom; // the stage has taken its operands, so decode moves on.
		src1     <= $urandom;
		src2     <= $urandom;
		imm      <= $urandom;
		op       <= exu_pkg::exu_op_e'($urandom % 24);
		src_sel  <= exu_pkg::src_sel_e'($urandom % 4);
	endtask

	// counts edges after the id_to_ex edge until the result is valid.
	task automatic wait_for_valid(output int edges);
		edges = 0;
		@(negedge clock);
		while (!exu_result_valid) begin
			check_flag("exu_stall", exu_stall, 1'b1);
			if (edges >= timeout_edges)
				stop_with_error("timed out waiting for exu_result_valid");
			@(posedge clock);
			edges++;
			@(negedge clock);
		end
		check_flag("exu_stall", exu_stall, 1'b0);
	endtask

	task automatic release_result();
		@(posedge clock);
		ex_to_wb <= 1'b1;
		@(posedge clock);
		ex_to_wb <= 1'b0;
		@(negedge clock);
		check_flag("exu_result_valid", exu_result_valid, 1'b0);
	endtask

	task automatic run_op(input exu_pkg::exu_op_e code, input exu_pkg::src_sel_e sel,
			input logic [w-1:0] pc_v, a, b, imm_v, input int edges_expected);
		logic [w-1:0] want;
		int           edges;
		want = expected_result(code, sel, pc_v, a, b, imm_v);
		issue_op(code, sel, pc_v, a, b, imm_v);
		wait_for_valid(edges);
		if (edges != edges_expected)
			stop_with_error($sformatf("%s became valid after %0d edges instead of %0d",
				code.name(), edges, edges_expected));
		check_op(code, exu_result, want);
		check_flag("zero_flag", zero_flag, want == '0);
		release_result();
	endtask

	task automatic reset_test();
		@(negedge clock);
		check_flag("exu_stall", exu_stall, 1'b0);
		check_flag("exu_result_valid", exu_result_valid, 1'b0);
		check_data("exu_result", exu_result, '0);
	endtask

	task automatic alu_test();
		for (int i = 0; i <= 9; i++)
			for (int s = 0; s < 4; s++)
				repeat (3)
					run_op(exu_pkg::exu_op_e'(i), exu_pkg::src_sel_e'(s), $urandom, $urandom,
						$urandom, $urandom, 1);
		run_op(exu_pkg::op_sub, exu_pkg::src_rs1_rs2, '0, 32'h1234_5678, 32'h1234_5678, '0, 1);
	endtask

	task automatic branch_test();
		for (int i = 10; i <= 15; i++)
			foreach (lhs[k])
				run_op(exu_pkg::exu_op_e'(i), exu_pkg::src_rs1_rs2, '0, lhs[k], rhs[k], '0, 1);
	endtask

	// first is the lowest opcode of the multiply or the divide family.
	task automatic iterative_test(input int first);
		for (int i = first; i < first + 4; i++) begin
			foreach (corner[j])
				foreach (corner[k])
					run_op(exu_pkg::exu_op_e'(i), exu_pkg::src_rs1_rs2, '0, corner[j], corner[k],
						'0, 33);
			repeat (8)
				run_op(exu_pkg::exu_op_e'(i), exu_pkg::src_rs1_rs2, '0, $urandom,
					$urandom >> ($urandom % 32), '0, 33);
		end
	endtask

	task automatic hold_test();
		logic [w-1:0] a;
		logic [w-1:0] b;
		logic [w-1:0] held;
		int           edges;
		int           delay;
		a     = $urandom;
		b     = $urandom;
		held  = expected_result(exu_pkg::op_mulhu, exu_pkg::src_rs1_rs2, '0, a, b, '0);
		delay = $urandom_range(3, 12);
		issue_op(exu_pkg::op_mulhu, exu_pkg::src_rs1_rs2, '0, a, b, '0);
		wait_for_valid(edges);
		if (edges != 33)
			stop_with_error($sformatf("op_mulhu became valid after %0d edges instead of 33",
				edges));
		for (int i = 0; i < delay; i++) begin
			if (i == 1)
				issue_op(exu_pkg::op_add, exu_pkg::src_rs1_rs2, '0, 32'h5, 32'h6, '0); // ignored.
			@(negedge clock);
			check_data("exu_result", exu_result, held);
			check_flag("exu_result_valid", exu_result_valid, 1'b1);
			check_flag("exu_stall", exu_stall, 1'b0);
		end
		release_result();
		run_op(exu_pkg::op_sub, exu_pkg::src_rs1_rs2, '0, a, b, '0, 1);
	endtask

	initial begin
		void'($urandom(10));
		reset    = 1'b1;
		pc       = '0;
		src1     = '0;
		src2     = '0;
		imm      = '0;
		src_sel  = exu_pkg::src_rs1_rs2;
		op       = exu_pkg::op_add;
		id_to_ex = 1'b0;
		ex_to_wb = 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		reset_test();
		alu_test();
		branch_test();
		iterative_test(16);
		iterative_test(20);
		hold_test();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
